/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int REG_COUNT   = 2 ** REG_ADDR_W;
    localparam int INSTR_BYTES = 4;               // PC step
    localparam int WORD_OFF_W  = 2;               // Byte offset inside a data word

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B,
        OP_HALT    = 6'h3F
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;                         // Operand B is the immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0] instr;
        logic              valid;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [DATA_W-1:0]     data_a;
        logic [DATA_W-1:0]     data_b;
        logic [DATA_W-1:0]     imm;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     data;
    } wb_t;

endpackage

`default_nettype wire

/* source/mips_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_fetch
    import mips_pkg::*;
#(
    parameter int IMEM_BYTES = 256
) (
    input  logic                          i_clock,
    input  logic                          i_rst,
    input  logic                          i_pipeline_enable,
    input  logic                          i_stall,
    input  logic                          i_halt_seen,
    input  logic                          i_imem_write_en,
    input  logic [$clog2(IMEM_BYTES)-1:0] i_imem_addr,
    input  logic [7:0]                    i_imem_data,
    output if_id_t                        o_if_id,
    output logic [DATA_W-1:0]             o_pc
);
    localparam int IA_W = $clog2(IMEM_BYTES);

    logic [7:0]        imem [IMEM_BYTES];
    logic [DATA_W-1:0] pc_q;
    logic              halted_q;
    if_id_t            if_id_q;
    logic [IA_W-1:0]   idx;
    logic [DATA_W-1:0] word;

    // Big-endian, byte at PC is the MSB
    assign idx  = pc_q[IA_W-1:0];
    assign word = {imem[idx], imem[idx + IA_W'(1)], imem[idx + IA_W'(2)], imem[idx + IA_W'(3)]};

    always_ff @(posedge i_clock) begin
        if (i_imem_write_en) begin
            imem[i_imem_addr] <= i_imem_data;     // Debug loader
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
            if_id_q  <= '0;
        end else if (i_pipeline_enable && !i_stall) begin
            if (halted_q || i_halt_seen) begin
                halted_q <= 1'b1;                 // PC frozen past HALT
                if_id_q  <= '0;
            end else begin
                pc_q          <= pc_q + DATA_W'(INSTR_BYTES);
                if_id_q.instr <= word;
                if_id_q.valid <= 1'b1;
            end
        end
    end

    assign o_if_id = if_id_q;
    assign o_pc    = pc_q;

    a_no_debug_write_running: assert property (
        @(posedge i_clock) disable iff (i_rst)
        i_imem_write_en |-> !i_pipeline_enable
    );

endmodule

`default_nettype wire

/* source/mips_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_decode
    import mips_pkg::*;
(
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  logic                  i_pipeline_enable,
    input  logic                  i_stall,
    input  if_id_t                i_if_id,
    input  wb_t                   i_wb,
    input  logic [REG_ADDR_W-1:0] i_reg_addr,
    output id_ex_t                o_id_ex,
    output logic                  o_halt_seen,
    output logic [DATA_W-1:0]     o_reg_data
);
    logic [DATA_W-1:0]     regs [REG_COUNT];
    logic                  wb_active;
    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [15:0]           imm16;
    ctrl_t                 ctrl;
    logic                  sign_ext;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;

    assign wb_active = i_pipeline_enable && i_wb.reg_write && (i_wb.dest != '0);

    // Same-cycle write is visible to readers
    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        if (wb_active && (i_wb.dest == addr)) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    assign opcode = i_if_id.instr[31:26];
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign funct  = i_if_id.instr[5:0];
    assign imm16  = i_if_id.instr[15:0];

    always_comb begin
        ctrl     = '0;
        sign_ext = 1'b0;
        if (i_if_id.valid) begin
            case (opcode_e'(opcode))
                OP_SPECIAL: begin
                    ctrl.reg_write = 1'b1;
                    case (funct_e'(funct))
                        FN_ADDU: ctrl.alu_op = ALU_ADD;
                        FN_SUBU: ctrl.alu_op = ALU_SUB;
                        FN_AND:  ctrl.alu_op = ALU_AND;
                        FN_OR:   ctrl.alu_op = ALU_OR;
                        FN_XOR:  ctrl.alu_op = ALU_XOR;
                        FN_SLT:  ctrl.alu_op = ALU_SLT;
                        default: ctrl.reg_write = 1'b0;   // Unknown funct is a NOP
                    endcase
                end
                OP_ADDI: begin
                    ctrl.alu_op    = ALU_ADD;
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    sign_ext       = 1'b1;
                end
                OP_ANDI: begin
                    ctrl.alu_op    = ALU_AND;
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                OP_ORI: begin
                    ctrl.alu_op    = ALU_OR;
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                OP_LUI: begin
                    ctrl.alu_op    = ALU_LUI;
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                OP_LW: begin
                    ctrl.alu_op    = ALU_ADD;
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    sign_ext       = 1'b1;
                end
                OP_SW: begin
                    ctrl.alu_op    = ALU_ADD;
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_write = 1'b1;
                    sign_ext       = 1'b1;
                end
                OP_HALT: ctrl.halt = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

    always_comb begin
        id_ex_d.ctrl   = ctrl;
        id_ex_d.data_a = read_reg(rs);
        id_ex_d.data_b = read_reg(rt);
        id_ex_d.imm    = {{16{sign_ext & imm16[15]}}, imm16};
        id_ex_d.rs     = rs;
        id_ex_d.rt     = rt;
        id_ex_d.dest   = (opcode == OP_SPECIAL) ? rd : rt;
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            id_ex_q <= '0;
        end else if (i_pipeline_enable) begin
            id_ex_q <= i_stall ? '0 : id_ex_d;    // Bubble on load-use
        end
    end

    assign o_id_ex     = id_ex_q;
    assign o_halt_seen = i_if_id.valid && (opcode == OP_HALT);
    assign o_reg_data  = read_reg(i_reg_addr);

    // Load-use bubble clears the hazard by the next enabled cycle
    a_single_stall: assert property (
        @(posedge i_clock) disable iff (i_rst)
        (i_pipeline_enable && i_stall) |=> !(i_pipeline_enable && i_stall)
    );

endmodule

`default_nettype wire

/* source/mips_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_execute
    import mips_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_rst,
    input  logic     i_pipeline_enable,
    input  id_ex_t   i_id_ex,
    input  fwd_sel_e i_fwd_a,
    input  fwd_sel_e i_fwd_b,
    input  ex_mem_t  i_ex_mem_fwd,
    input  wb_t      i_wb,
    output ex_mem_t  o_ex_mem
);
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] result;
    ex_mem_t           ex_mem_q;

    function automatic logic [DATA_W-1:0] pick(
        input fwd_sel_e          sel,
        input logic [DATA_W-1:0] stage_val
    );
        case (sel)
            FWD_MEM: return i_ex_mem_fwd.alu_result;
            FWD_WB:  return i_wb.data;
            default: return stage_val;
        endcase
    endfunction

    assign op_a  = pick(i_fwd_a, i_id_ex.data_a);
    assign reg_b = pick(i_fwd_b, i_id_ex.data_b);    // Also the store data
    assign op_b  = i_id_ex.ctrl.alu_src ? i_id_ex.imm : reg_b;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_LUI: result = {op_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            ex_mem_q <= '0;
        end else if (i_pipeline_enable) begin
            ex_mem_q.ctrl       <= i_id_ex.ctrl;
            ex_mem_q.alu_result <= result;
            ex_mem_q.store_data <= reg_b;
            ex_mem_q.dest       <= i_id_ex.dest;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

`default_nettype wire

/* source/mips_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_memory
    import mips_pkg::*;
#(
    parameter int DMEM_WORDS = 32
) (
    input  logic                          i_clock,
    input  logic                          i_rst,
    input  logic                          i_pipeline_enable,
    input  ex_mem_t                       i_ex_mem,
    input  logic [$clog2(DMEM_WORDS)-1:0] i_mem_addr,
    output wb_t                           o_wb,
    output logic [DATA_W-1:0]             o_mem_data,
    output logic                          o_halt
);
    localparam int DA_W = $clog2(DMEM_WORDS);

    logic [DATA_W-1:0] dmem [DMEM_WORDS];
    logic [DA_W-1:0]   idx;
    logic [DATA_W-1:0] load_data;
    wb_t               wb_q;
    logic              halt_q;

    assign idx       = i_ex_mem.alu_result[DA_W+WORD_OFF_W-1:WORD_OFF_W];
    assign load_data = dmem[idx];

    always_ff @(posedge i_clock) begin
        if (i_pipeline_enable && i_ex_mem.ctrl.mem_write) begin
            dmem[idx] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            wb_q   <= '0;
            halt_q <= 1'b0;
        end else if (i_pipeline_enable) begin
            wb_q.reg_write <= i_ex_mem.ctrl.reg_write;
            wb_q.dest      <= i_ex_mem.dest;
            wb_q.data      <= i_ex_mem.ctrl.mem_read ? load_data : i_ex_mem.alu_result;
            if (i_ex_mem.ctrl.halt) begin
                halt_q <= 1'b1;                   // HALT enters writeback
            end
        end
    end

    assign o_wb       = wb_q;
    assign o_halt     = halt_q;
    assign o_mem_data = dmem[i_mem_addr];

    a_halt_sticky: assert property (
        @(posedge i_clock)
        $fell(o_halt) |-> $past(i_rst)
    );

endmodule

`default_nettype wire

/* source/mips_hazard.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_hazard
    import mips_pkg::*;
(
    input  id_ex_t   i_id_ex,
    input  ex_mem_t  i_ex_mem,
    input  wb_t      i_wb,
    input  if_id_t   i_if_id,
    output fwd_sel_e o_fwd_a,
    output fwd_sel_e o_fwd_b,
    output logic     o_stall
);
    logic [REG_ADDR_W-1:0] id_rs;
    logic [REG_ADDR_W-1:0] id_rt;
    logic                  load_in_ex;

    // Younger result in MEM wins over WB
    function automatic fwd_sel_e fwd_for(input logic [REG_ADDR_W-1:0] src);
        if (i_ex_mem.ctrl.reg_write && (i_ex_mem.dest != '0) && (i_ex_mem.dest == src)) begin
            return FWD_MEM;
        end
        if (i_wb.reg_write && (i_wb.dest != '0) && (i_wb.dest == src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign o_fwd_a = fwd_for(i_id_ex.rs);
    assign o_fwd_b = fwd_for(i_id_ex.rt);

    assign id_rs      = i_if_id.instr[25:21];
    assign id_rt      = i_if_id.instr[20:16];
    assign load_in_ex = i_id_ex.ctrl.mem_read && (i_id_ex.dest != '0);

    assign o_stall = load_in_ex && i_if_id.valid &&
                     ((i_id_ex.dest == id_rs) || (i_id_ex.dest == id_rt));

endmodule

`default_nettype wire

/* source/mips_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_pipeline
    import mips_pkg::*;
#(
    parameter int IMEM_BYTES = 256,
    parameter int DMEM_WORDS = 32
) (
    input  logic                          i_clock,
    input  logic                          i_rst,
    input  logic                          i_pipeline_enable,
    input  logic                          i_imem_write_en,
    input  logic [$clog2(IMEM_BYTES)-1:0] i_imem_addr,
    input  logic [7:0]                    i_imem_data,
    input  logic [REG_ADDR_W-1:0]         i_reg_addr,
    input  logic [$clog2(DMEM_WORDS)-1:0] i_mem_addr,
    output logic [DATA_W-1:0]             o_reg_data,
    output logic [DATA_W-1:0]             o_mem_data,
    output logic [DATA_W-1:0]             o_pc,
    output logic                          o_halt
);
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    wb_t      wb;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall;
    logic     halt_seen;

    mips_fetch #(
        .IMEM_BYTES(IMEM_BYTES)
    ) u_fetch (
        .i_clock          (i_clock),
        .i_rst            (i_rst),
        .i_pipeline_enable(i_pipeline_enable),
        .i_stall          (stall),
        .i_halt_seen      (halt_seen),
        .i_imem_write_en  (i_imem_write_en),
        .i_imem_addr      (i_imem_addr),
        .i_imem_data      (i_imem_data),
        .o_if_id          (if_id),
        .o_pc             (o_pc)
    );

    mips_decode u_decode (
        .i_clock          (i_clock),
        .i_rst            (i_rst),
        .i_pipeline_enable(i_pipeline_enable),
        .i_stall          (stall),
        .i_if_id          (if_id),
        .i_wb             (wb),
        .i_reg_addr       (i_reg_addr),
        .o_id_ex          (id_ex),
        .o_halt_seen      (halt_seen),
        .o_reg_data       (o_reg_data)
    );

    mips_execute u_execute (
        .i_clock          (i_clock),
        .i_rst            (i_rst),
        .i_pipeline_enable(i_pipeline_enable),
        .i_id_ex          (id_ex),
        .i_fwd_a          (fwd_a),
        .i_fwd_b          (fwd_b),
        .i_ex_mem_fwd     (ex_mem),
        .i_wb             (wb),
        .o_ex_mem         (ex_mem)
    );

    mips_memory #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_memory (
        .i_clock          (i_clock),
        .i_rst            (i_rst),
        .i_pipeline_enable(i_pipeline_enable),
        .i_ex_mem         (ex_mem),
        .i_mem_addr       (i_mem_addr),
        .o_wb             (wb),
        .o_mem_data       (o_mem_data),
        .o_halt           (o_halt)
    );

    mips_hazard u_hazard (
        .i_id_ex (id_ex),
        .i_ex_mem(ex_mem),
        .i_wb    (wb),
        .i_if_id (if_id),
        .o_fwd_a (fwd_a),
        .o_fwd_b (fwd_b),
        .o_stall (stall)
    );

endmodule

`default_nettype wire

/* test/tb_mips_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips_pipeline
    import mips_pkg::*;
();
    localparam int IMEM_BYTES = 256;
    localparam int DMEM_WORDS = 32;
    localparam int HALT_LIMIT = 200;          // Cycles allowed per program

    logic        i_clock;
    logic        i_rst;
    logic        i_pipeline_enable;
    logic        i_imem_write_en;
    logic [7:0]  i_imem_addr;
    logic [7:0]  i_imem_data;
    logic [4:0]  i_reg_addr;
    logic [4:0]  i_mem_addr;
    logic [31:0] o_reg_data;
    logic [31:0] o_mem_data;
    logic [31:0] o_pc;
    logic        o_halt;

    logic [31:0] prog [$];
    logic [31:0] lcg_state;
    int          errors;

    mips_pipeline #(
        .IMEM_BYTES(IMEM_BYTES),
        .DMEM_WORDS(DMEM_WORDS)
    ) dut_i (
        .i_clock          (i_clock),
        .i_rst            (i_rst),
        .i_pipeline_enable(i_pipeline_enable),
        .i_imem_write_en  (i_imem_write_en),
        .i_imem_addr      (i_imem_addr),
        .i_imem_data      (i_imem_data),
        .i_reg_addr       (i_reg_addr),
        .i_mem_addr       (i_mem_addr),
        .o_reg_data       (o_reg_data),
        .o_mem_data       (o_mem_data),
        .o_pc             (o_pc),
        .o_halt           (o_halt)
    );

    initial begin
        i_clock = 1'b0;
        forever begin
            #20 i_clock = ~i_clock;
        end
    end

    function automatic logic [31:0] rtype_word(funct_e fn, logic [4:0] rd, logic [4:0] rs,
                                               logic [4:0] rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    // Operand order follows assembly, op rt, rs, imm
    function automatic logic [31:0] itype_word(opcode_e op, logic [4:0] rt, logic [4:0] rs,
                                               logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sign_ext16(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic apply_reset();
        @(posedge i_clock);
        i_rst             <= 1'b1;
        i_pipeline_enable <= 1'b0;
        repeat (3) @(posedge i_clock);
        i_rst <= 1'b0;
    endtask

    // Big-endian bytes, core held while loading
    task automatic load_program();
        logic [31:0] word;
        for (int i = 0; i < prog.size(); i++) begin
            word = prog[i];
            for (int b = 0; b < 4; b++) begin
                @(posedge i_clock);
                i_imem_write_en <= 1'b1;
                i_imem_addr     <= 8'(4 * i + b);
                i_imem_data     <= word[31 - 8 * b -: 8];
            end
        end
        @(posedge i_clock);
        i_imem_write_en <= 1'b0;
    endtask

    task automatic wait_for_halt();
        int n;
        n = 0;
        do begin
            @(negedge i_clock);
            n++;
        end while (!o_halt && n < HALT_LIMIT);
        if (!o_halt) begin
            $display("Timeout: o_halt did not rise within %0d cycles", HALT_LIMIT);
            errors++;
        end
    endtask

    task automatic run_program();
        @(posedge i_clock);
        i_pipeline_enable <= 1'b1;
        wait_for_halt();
        @(posedge i_clock);
        i_pipeline_enable <= 1'b0;
    endtask

    task automatic expect_reg(logic [4:0] r, logic [31:0] exp);
        @(posedge i_clock);
        i_reg_addr <= r;
        @(negedge i_clock);
        if (o_reg_data !== exp) begin
            $display("Mismatch: o_reg_data (r%0d) = %h, expected %h", r, o_reg_data, exp);
            errors++;
        end
    endtask

    task automatic mem_matches(logic [4:0] w, logic [31:0] exp);
        @(posedge i_clock);
        i_mem_addr <= w;
        @(negedge i_clock);
        if (o_mem_data !== exp) begin
            $display("Mismatch: o_mem_data (word %0d) = %h, expected %h", w, o_mem_data, exp);
            errors++;
        end
    endtask

    task automatic signal_matches(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(string name, int start);
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic const_to_reg(logic [4:0] r, logic [31:0] value);
        prog.push_back(itype_word(OP_LUI, r, 5'd0, value[31:16]));
        prog.push_back(itype_word(OP_ORI, r, r, value[15:0]));
    endtask

    // Each result feeds the next instruction directly
    task automatic build_chain(logic [31:0] a, logic [31:0] b);
        prog.delete();
        const_to_reg(5'd1, a);
        const_to_reg(5'd2, b);
        prog.push_back(rtype_word(FN_ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(rtype_word(FN_SUBU, 5'd4, 5'd1, 5'd3));
        prog.push_back(rtype_word(FN_AND, 5'd5, 5'd4, 5'd2));
        prog.push_back(rtype_word(FN_OR, 5'd6, 5'd5, 5'd1));
        prog.push_back(rtype_word(FN_XOR, 5'd7, 5'd6, 5'd3));
        prog.push_back(rtype_word(FN_SLT, 5'd8, 5'd7, 5'd4));
        prog.push_back({OP_HALT, 26'd0});
    endtask

    task automatic verify_chain(logic [31:0] a, logic [31:0] b);
        logic [31:0] e [9];
        e[0] = '0;
        e[1] = a;
        e[2] = b;
        e[3] = a + b;
        e[4] = a - e[3];
        e[5] = e[4] & b;
        e[6] = e[5] | a;
        e[7] = e[6] ^ e[3];
        e[8] = ($signed(e[7]) < $signed(e[4])) ? 32'd1 : 32'd0;
        for (int r = 1; r <= 8; r++) begin
            expect_reg(5'(r), e[r]);
        end
    endtask

    task automatic alu_chain_test();
        logic [31:0] a;
        logic [31:0] b;
        int          start;
        start = errors;
        a     = next_rand();
        b     = next_rand();
        apply_reset();
        build_chain(a, b);
        load_program();
        run_program();
        verify_chain(a, b);
        report_test("alu chain with forwarding", start);
    endtask

    task automatic immediate_test();
        logic [31:0] r1;
        logic [31:0] r2;
        int          start;
        start = errors;
        apply_reset();
        prog.delete();
        prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'hFFFB));
        prog.push_back(itype_word(OP_LUI, 5'd2, 5'd0, 16'h8001));
        prog.push_back(itype_word(OP_ORI, 5'd3, 5'd2, 16'h8F0F));
        prog.push_back(itype_word(OP_ANDI, 5'd4, 5'd1, 16'h9234));
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd0, 16'h1234));
        prog.push_back(itype_word(OP_ADDI, 5'd5, 5'd1, 16'h0007));
        prog.push_back({OP_HALT, 26'd0});
        load_program();
        run_program();
        r1 = sign_ext16(16'hFFFB);
        r2 = {16'h8001, 16'h0000};
        expect_reg(5'd1, r1);
        expect_reg(5'd2, r2);
        expect_reg(5'd3, r2 | {16'h0000, 16'h8F0F});
        expect_reg(5'd4, r1 & {16'h0000, 16'h9234});
        expect_reg(5'd0, 32'd0);
        expect_reg(5'd5, r1 + sign_ext16(16'h0007));
        report_test("immediates", start);
    endtask

    task automatic memory_test();
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        int          start;
        start = errors;
        x1    = next_rand();
        x2    = next_rand();
        x3    = next_rand();
        apply_reset();
        prog.delete();
        const_to_reg(5'd1, x1);
        const_to_reg(5'd2, x2);
        const_to_reg(5'd3, x3);
        prog.push_back(itype_word(OP_SW, 5'd1, 5'd0, 16'h0000));
        prog.push_back(itype_word(OP_SW, 5'd2, 5'd0, 16'h0004));
        prog.push_back(itype_word(OP_ADDI, 5'd10, 5'd0, 16'h000C));
        prog.push_back(itype_word(OP_SW, 5'd3, 5'd10, 16'h0008));      // Byte 20, word 5
        prog.push_back(itype_word(OP_LW, 5'd4, 5'd0, 16'h0000));
        prog.push_back(rtype_word(FN_ADDU, 5'd5, 5'd4, 5'd1));
        prog.push_back(itype_word(OP_LW, 5'd6, 5'd0, 16'h0004));
        prog.push_back(rtype_word(FN_ADDU, 5'd7, 5'd6, 5'd2));
        prog.push_back(itype_word(OP_LW, 5'd8, 5'd10, 16'h0008));
        prog.push_back(rtype_word(FN_ADDU, 5'd9, 5'd8, 5'd3));
        prog.push_back(itype_word(OP_LW, 5'd11, 5'd10, 16'hFFF8));     // 12 - 8, word 1
        prog.push_back(rtype_word(FN_ADDU, 5'd12, 5'd11, 5'd11));
        prog.push_back({OP_HALT, 26'd0});
        load_program();
        run_program();
        mem_matches(5'd0, x1);
        mem_matches(5'd1, x2);
        mem_matches(5'd5, x3);
        expect_reg(5'd4, x1);
        expect_reg(5'd5, x1 + x1);
        expect_reg(5'd7, x2 + x2);
        expect_reg(5'd9, x3 + x3);
        expect_reg(5'd12, x2 + x2);
        report_test("memory and load-use", start);
    endtask

    task automatic halt_test();
        logic [31:0] halt_addr;
        int          start;
        start     = errors;
        halt_addr = 32'd8;                    // Third instruction
        apply_reset();
        prog.delete();
        prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h0011));
        prog.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'h0022));
        prog.push_back({OP_HALT, 26'd0});
        prog.push_back(itype_word(OP_ADDI, 5'd3, 5'd0, 16'h0033));
        prog.push_back(itype_word(OP_ADDI, 5'd4, 5'd0, 16'h0044));
        load_program();
        run_program();
        @(negedge i_clock);
        signal_matches("o_halt", {31'd0, o_halt}, 32'd1);
        signal_matches("o_pc", o_pc, halt_addr + 32'd4);
        expect_reg(5'd1, 32'h0000_0011);
        expect_reg(5'd2, 32'h0000_0022);
        expect_reg(5'd3, 32'd0);
        expect_reg(5'd4, 32'd0);
        report_test("halt", start);
    endtask

    task automatic freeze_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc_held;
        int          start;
        start = errors;
        a     = next_rand();
        b     = next_rand();
        apply_reset();
        build_chain(a, b);
        load_program();
        @(posedge i_clock);
        i_pipeline_enable <= 1'b1;
        repeat (5) @(posedge i_clock);
        i_pipeline_enable <= 1'b0;            // Freeze mid-program
        @(negedge i_clock);
        pc_held = o_pc;
        repeat (10) begin
            @(negedge i_clock);
            signal_matches("o_pc", o_pc, pc_held);
        end
        run_program();
        verify_chain(a, b);
        report_test("enable freeze", start);
    endtask

    task automatic reset_test();
        int start;
        start = errors;
        apply_reset();
        build_chain(next_rand(), next_rand());
        load_program();
        run_program();
        apply_reset();
        @(negedge i_clock);
        signal_matches("o_halt", {31'd0, o_halt}, 32'd0);
        signal_matches("o_pc", o_pc, 32'd0);
        for (int r = 0; r < 32; r++) begin
            expect_reg(5'(r), 32'd0);
        end
        report_test("reset", start);
    endtask

    initial begin
        i_rst             = 1'b1;
        i_pipeline_enable = 1'b0;
        i_imem_write_en   = 1'b0;
        i_imem_addr       = '0;
        i_imem_data       = '0;
        i_reg_addr        = '0;
        i_mem_addr        = '0;
        lcg_state         = 32'd76273;
        errors            = 0;

        alu_chain_test();
        immediate_test();
        memory_test();
        halt_test();
        freeze_test();
        reset_test();

        $display("tests run: 6, errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/mips_pkg.sv
source/mips_fetch.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_memory.sv
source/mips_hazard.sv
source/mips_pipeline.sv
test/tb_mips_pipeline.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mips_pipeline -f verilog.f -o sim_mips
status=0
./obj_dir/sim_mips > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
